//--- tb.f
verilog/cache_pkg.sv
verilog/cache_ctrl.sv
verilog/way_lookup.sv
verilog/tag_next_state.sv
verilog/data_next_state.sv
verilog/set_storage.sv
verilog/cache_top.sv
bench/tb_cache.sv

//--- Bender.yml
package:
  name: cache

sources:
  - files:
      - verilog/cache_pkg.sv
      - verilog/cache_ctrl.sv
      - verilog/way_lookup.sv
      - verilog/tag_next_state.sv
      - verilog/data_next_state.sv
      - verilog/set_storage.sv
      - verilog/cache_top.sv
  - target: test
    files:
      - bench/tb_cache.sv

//--- bench/tb_cache.sv
`default_nettype none

module tb_cache;
    timeunit 1ns;
    timeprecision 1ps;

    import cache_pkg::*;

    localparam int NUM_SETS = 4;
    localparam int REQ_DEPTH = 4;
    localparam int MEM_CREDITS = 2;
    localparam int MEM_SIZE = 4096;
    localparam int NUM_STIM = 28;
    localparam int HOLD_CYCLES = 40;
    localparam int TIMEOUT = 2000;

    typedef struct packed {
        logic hold;
        cpu_op_e op;
        access_size_e size;
        logic [31:0] addr;
        logic [31:0] wdata;
    } stim_t;

    typedef struct packed {
        cpu_op_e op;
        logic [31:0] rdata;
        logic hit;
        logic [31:0] cyc;
    } exp_rsp_t;

    typedef struct packed {
        logic [LINE_BITS-1:0] data;
        logic [31:0] due;
    } fill_t;

    logic clk;
    logic arst_n;
    logic cpu_req_valid;
    cpu_req_t cpu_req;
    logic cpu_req_credit;
    logic cpu_rsp_valid;
    cpu_rsp_t cpu_rsp;
    logic mem_req_valid;
    mem_req_t mem_req;
    logic mem_req_credit;
    logic mem_rsp_valid;
    mem_rsp_t mem_rsp;

    stim_t stim [NUM_STIM];
    stim_t issued [$];
    exp_rsp_t exp_rsp [$];
    mem_req_t exp_mem [$];
    fill_t fills [$];
    fill_t drv_fill;
    logic [7:0] mem_bytes [MEM_SIZE];
    logic [7:0] ref_bytes [MEM_SIZE];
    logic m_valid [NUM_SETS][NUM_WAYS];
    logic m_dirty [NUM_SETS][NUM_WAYS];
    logic [LINE_ADDR_BITS-1:0] m_line [NUM_SETS][NUM_WAYS];
    int m_rr [NUM_SETS];
    int seed = 76;
    int cyc;
    int cpu_credits;
    int mem_crd;
    int owed;
    int hold_cnt;
    int credit_cnt;
    int rsp_cnt;
    int last_due;

    cache_top #(
        .NUM_SETS(NUM_SETS),
        .REQ_DEPTH(REQ_DEPTH),
        .MEM_CREDITS(MEM_CREDITS)
    ) i_dut (
        .clk(clk),
        .arst_n(arst_n),
        .cpu_req_valid(cpu_req_valid),
        .cpu_req(cpu_req),
        .cpu_req_credit(cpu_req_credit),
        .cpu_rsp_valid(cpu_rsp_valid),
        .cpu_rsp(cpu_rsp),
        .mem_req_valid(mem_req_valid),
        .mem_req(mem_req),
        .mem_req_credit(mem_req_credit),
        .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp(mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("ERROR at %0d ns: %s", $time, what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [LINE_BITS-1:0] got,
                               input logic [LINE_BITS-1:0] exp);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // Mixes every address bit into the byte
    function automatic logic [7:0] fill_pattern(input logic [31:0] a);
        return a[7:0] ^ {a[11:8], a[15:12]} ^ a[23:16] ^ a[31:24] ^ 8'ha5;
    endfunction

    function automatic logic [LINE_BITS-1:0] ref_line(input logic [LINE_ADDR_BITS-1:0] line);
        logic [LINE_BITS-1:0] d;
        for (int i = 0; i < LINE_BYTES; i++) begin
            d[8*i +: 8] = ref_bytes[line * LINE_BYTES + i];
        end
        return d;
    endfunction

    function automatic logic [LINE_BITS-1:0] mem_line(input logic [LINE_ADDR_BITS-1:0] line);
        logic [LINE_BITS-1:0] d;
        for (int i = 0; i < LINE_BYTES; i++) begin
            d[8*i +: 8] = mem_bytes[line * LINE_BYTES + i];
        end
        return d;
    endfunction

    // Four bytes from the offset, zero past the line end
    function automatic logic [31:0] ref_window(input logic [31:0] addr);
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 4; i++) begin
            if (int'(addr[3:0]) + i < LINE_BYTES) begin
                w[8*i +: 8] = ref_bytes[addr + i];
            end
        end
        return w;
    endfunction

    function automatic int size_bytes(input access_size_e size);
        case (size)
            SZ_BYTE: return 1;
            SZ_HALF: return 2;
            default: return 4;
        endcase
    endfunction

    // Cache and memory view at the moment a request leaves the queue
    task automatic model_dequeue(input stim_t s);
        logic [LINE_ADDR_BITS-1:0] line;
        int set;
        int way;
        logic [31:0] old;
        exp_rsp_t e;
        mem_req_t m;
        line = s.addr[ADDR_BITS-1:OFFSET_BITS];
        set = int'(line) % NUM_SETS;
        way = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (m_valid[set][w] && (m_line[set][w] == line)) way = w;
        end
        e.hit = (way >= 0);
        if (way < 0) begin
            for (int w = NUM_WAYS - 1; w >= 0; w--) begin
                if (!m_valid[set][w]) way = w;
            end
            if (way < 0) begin
                way = m_rr[set];  // Full set
                m_rr[set] = (m_rr[set] + 1) % NUM_WAYS;
            end
            if (m_valid[set][way] && m_dirty[set][way]) begin
                m.op = MEM_WR;
                m.line_addr = m_line[set][way];
                m.data = ref_line(m_line[set][way]);
                exp_mem.push_back(m);
            end
            m.op = MEM_RD;
            m.line_addr = line;
            m.data = '0;
            exp_mem.push_back(m);
            m_valid[set][way] = 1'b1;
            m_line[set][way] = line;
            m_dirty[set][way] = 1'b0;
        end
        old = ref_window(s.addr);
        e.op = s.op;
        e.cyc = cyc;
        if (s.op == LD) begin
            e.rdata = '0;
            for (int i = 0; i < size_bytes(s.size); i++) begin
                e.rdata[8*i +: 8] = old[8*i +: 8];
            end
        end else begin
            e.rdata = old;
            for (int i = 0; i < size_bytes(s.size); i++) begin
                ref_bytes[s.addr + i] = s.wdata[8*i +: 8];
            end
            m_dirty[set][way] = 1'b1;
        end
        exp_rsp.push_back(e);
    endtask

    task automatic load_table();
        stim[0] = '{1'b0, LD, SZ_BYTE, 32'h0000_0013, 32'h0};  // Cold misses, set 1
        stim[1] = '{1'b0, LD, SZ_HALF, 32'h0000_0016, 32'h0};
        stim[2] = '{1'b0, LD, SZ_WORD, 32'h0000_0018, 32'h0};
        stim[3] = '{1'b0, LD, SZ_WORD, 32'h0000_0050, 32'h0};
        stim[4] = '{1'b0, ST, SZ_WORD, 32'h0000_0024, 32'hcafe_f00d};
        stim[5] = '{1'b0, LD, SZ_WORD, 32'h0000_0024, 32'h0};
        stim[6] = '{1'b0, ST, SZ_BYTE, 32'h0000_0025, 32'h0000_005a};
        stim[7] = '{1'b0, ST, SZ_HALF, 32'h0000_0026, 32'h0000_1234};
        stim[8] = '{1'b0, LD, SZ_WORD, 32'h0000_0024, 32'h0};
        stim[9] = '{1'b0, ST, SZ_HALF, 32'h0000_002e, 32'h0000_beef};  // Window past line end
        stim[10] = '{1'b0, LD, SZ_HALF, 32'h0000_002e, 32'h0};
        stim[11] = '{1'b0, ST, SZ_BYTE, 32'h0000_002f, 32'h0000_0077};
        stim[12] = '{1'b0, LD, SZ_WORD, 32'h0000_002c, 32'h0};
        stim[13] = '{1'b0, ST, SZ_WORD, 32'h0000_0000, 32'h1111_1111};  // Fill set 0 dirty
        stim[14] = '{1'b0, ST, SZ_BYTE, 32'h0000_0041, 32'h0000_0022};
        stim[15] = '{1'b0, ST, SZ_HALF, 32'h0000_0082, 32'h0000_3333};
        stim[16] = '{1'b0, ST, SZ_WORD, 32'h0000_00c4, 32'h4444_4444};
        stim[17] = '{1'b0, LD, SZ_WORD, 32'h0000_0108, 32'h0};  // Fifth line evicts
        stim[18] = '{1'b0, LD, SZ_WORD, 32'h0000_0000, 32'h0};
        stim[19] = '{1'b0, LD, SZ_BYTE, 32'h0000_0041, 32'h0};
        stim[20] = '{1'b0, LD, SZ_HALF, 32'h0000_0082, 32'h0};
        stim[21] = '{1'b1, LD, SZ_WORD, 32'h0000_0030, 32'h0};  // Memory holds its credits
        stim[22] = '{1'b0, LD, SZ_WORD, 32'h0000_0070, 32'h0};
        stim[23] = '{1'b0, ST, SZ_WORD, 32'h0000_00b0, 32'h55aa_55aa};
        stim[24] = '{1'b0, LD, SZ_BYTE, 32'h0000_00f3, 32'h0};
        stim[25] = '{1'b0, ST, SZ_HALF, 32'h0000_0132, 32'h0000_6789};
        stim[26] = '{1'b0, LD, SZ_WORD, 32'h0000_00b0, 32'h0};
        stim[27] = '{1'b0, LD, SZ_WORD, 32'h0000_00c4, 32'h0};
    endtask

    always @(posedge clk) begin : monitor
        stim_t s;
        exp_rsp_t er;
        mem_req_t em;
        fill_t f;
        if (arst_n) begin
            if (cpu_req_credit) begin
                cpu_credits++;
                credit_cnt++;
                if (cpu_credits > REQ_DEPTH) report_error("more CPU credits returned than sent");
                if (issued.size() == 0) report_error("credit returned for no request");
                s = issued.pop_front();
                model_dequeue(s);
            end
            if (mem_req_valid) begin
                if (mem_crd == 0) report_error("memory request sent without a memory credit");
                if (exp_mem.size() == 0) report_error("memory request that the model did not expect");
                mem_crd--;
                owed++;
                em = exp_mem.pop_front();
                check_value("mem_req.op", mem_req.op, em.op);
                check_value("mem_req.line_addr", mem_req.line_addr, em.line_addr);
                if (em.op == MEM_WR) begin
                    check_value("mem_req.data", mem_req.data, em.data);
                    for (int i = 0; i < LINE_BYTES; i++) begin
                        mem_bytes[mem_req.line_addr * LINE_BYTES + i] = mem_req.data[8*i +: 8];
                    end
                end else begin
                    f.data = mem_line(mem_req.line_addr);
                    f.due = cyc + 1 + ($unsigned($random(seed)) % 6);
                    if (int'(f.due) <= last_due) f.due = last_due + 1;  // Fills stay in order
                    last_due = f.due;
                    fills.push_back(f);
                end
            end
            if (mem_req_credit) mem_crd++;
            if (cpu_rsp_valid) begin
                if (exp_rsp.size() == 0) report_error("response arrived with no request pending");
                er = exp_rsp.pop_front();
                // Only the request being answered has left the queue
                check_value("credits ahead of responses", credit_cnt - rsp_cnt, 1);
                check_value("cpu_rsp.op", cpu_rsp.op, er.op);
                check_value("cpu_rsp.rdata", cpu_rsp.rdata, er.rdata);
                if (er.hit) check_value("hit latency", cyc - int'(er.cyc), 2);
                rsp_cnt++;
            end
            cyc++;
        end
    end

    // Memory side inputs
    always @(negedge clk) begin
        mem_req_credit = 1'b0;
        mem_rsp_valid = 1'b0;
        if (hold_cnt > 0) begin
            hold_cnt--;
        end else if (owed > 0) begin
            mem_req_credit = 1'b1;
            owed--;
        end
        if ((fills.size() > 0) && (int'(fills[0].due) <= cyc)) begin
            drv_fill = fills.pop_front();
            mem_rsp_valid = 1'b1;
            mem_rsp.data = drv_fill.data;
        end
    end

    initial begin
        int waited;
        arst_n = 1'b0;
        cpu_req_valid = 1'b0;
        cpu_req = '0;
        mem_req_credit = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp = '0;
        cyc = 0;
        cpu_credits = REQ_DEPTH;
        mem_crd = MEM_CREDITS;
        owed = 0;
        hold_cnt = 0;
        credit_cnt = 0;
        rsp_cnt = 0;
        last_due = 0;
        for (int a = 0; a < MEM_SIZE; a++) begin
            mem_bytes[a] = fill_pattern(a);
            ref_bytes[a] = fill_pattern(a);
        end
        for (int st = 0; st < NUM_SETS; st++) begin
            m_rr[st] = 0;
            for (int w = 0; w < NUM_WAYS; w++) begin
                m_valid[st][w] = 1'b0;
                m_dirty[st][w] = 1'b0;
                m_line[st][w] = '0;
            end
        end
        load_table();
        repeat (10) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < NUM_STIM; i++) begin
            waited = 0;
            while (cpu_credits == 0) begin
                cpu_req_valid = 1'b0;
                @(negedge clk);
                waited++;
                if (waited > TIMEOUT) report_error("timed out waiting for a CPU credit");
            end
            if (stim[i].hold) begin
                cpu_req_valid = 1'b0;
                @(posedge clk);
                hold_cnt = HOLD_CYCLES;
                @(negedge clk);
            end
            cpu_req_valid = 1'b1;
            cpu_req.op = stim[i].op;
            cpu_req.size = stim[i].size;
            cpu_req.addr = stim[i].addr;
            cpu_req.wdata = stim[i].wdata;
            cpu_credits--;
            issued.push_back(stim[i]);
            @(negedge clk);
        end
        cpu_req_valid = 1'b0;
        waited = 0;
        while (rsp_cnt < NUM_STIM) begin
            @(negedge clk);
            waited++;
            if (waited > 5 * TIMEOUT) report_error("timed out waiting for the last responses");
        end
        check_value("unsent memory requests", exp_mem.size(), 0);
        check_value("undelivered fills", fills.size(), 0);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/cache_top.sv
`default_nettype none

module cache_top #(
    parameter int NUM_SETS = 4,
    parameter int REQ_DEPTH = 4,
    parameter int MEM_CREDITS = 2
) (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                cpu_req_valid,
    input  cache_pkg::cpu_req_t cpu_req,
    output logic                cpu_req_credit,
    output logic                cpu_rsp_valid,
    output cache_pkg::cpu_rsp_t cpu_rsp,
    output logic                mem_req_valid,
    output cache_pkg::mem_req_t mem_req,
    input  logic                mem_req_credit,
    input  logic                mem_rsp_valid,
    input  cache_pkg::mem_rsp_t mem_rsp
);
    import cache_pkg::*;

    localparam int IDX_BITS = $clog2(NUM_SETS);
    localparam int TAG_BITS = ADDR_BITS - OFFSET_BITS - IDX_BITS;

    cpu_req_t cur_req;
    logic [IDX_BITS-1:0] set_idx;
    logic store_en;
    logic [LINE_BITS-1:0] fill_line;
    logic [NUM_WAYS*TAG_BITS-1:0] tags;
    logic [NUM_WAYS*TAG_BITS-1:0] tags_next;
    logic [NUM_WAYS*LINE_BITS-1:0] data;
    logic [NUM_WAYS*LINE_BITS-1:0] data_next;
    line_state_e [NUM_WAYS-1:0] line_states;
    line_state_e [NUM_WAYS-1:0] next_states;
    logic [$clog2(NUM_WAYS)-1:0] rr_ptr;
    logic hit;
    logic [NUM_WAYS-1:0] hit_way;
    logic [NUM_WAYS-1:0] victim_way;
    logic [NUM_WAYS-1:0] sel_way;
    logic [LINE_BITS-1:0] evict_line;
    logic [31:0] store_rdata;
    logic [31:0] load_rdata;
    logic tag_we;
    logic data_we;
    logic state_we;
    logic fill_sel;
    logic rr_advance;

    cache_ctrl #(
        .NUM_SETS(NUM_SETS),
        .REQ_DEPTH(REQ_DEPTH),
        .MEM_CREDITS(MEM_CREDITS)
    ) i_ctrl (
        .clk(clk),
        .arst_n(arst_n),
        .cpu_req_valid(cpu_req_valid),
        .cpu_req(cpu_req),
        .cpu_req_credit(cpu_req_credit),
        .cpu_rsp_valid(cpu_rsp_valid),
        .cpu_rsp(cpu_rsp),
        .mem_req_valid(mem_req_valid),
        .mem_req(mem_req),
        .mem_req_credit(mem_req_credit),
        .mem_rsp_valid(mem_rsp_valid),
        .mem_rsp(mem_rsp),
        .set_idx(set_idx),
        .cur_req(cur_req),
        .store_en(store_en),
        .fill_line(fill_line),
        .tags(tags),
        .line_states(line_states),
        .hit(hit),
        .hit_way(hit_way),
        .victim_way(victim_way),
        .sel_way(sel_way),
        .evict_line(evict_line),
        .store_rdata(store_rdata),
        .load_rdata(load_rdata),
        .tag_we(tag_we),
        .data_we(data_we),
        .state_we(state_we),
        .next_states(next_states),
        .fill_sel(fill_sel),
        .rr_advance(rr_advance)
    );

    way_lookup #(.NUM_SETS(NUM_SETS)) i_lookup (
        .addr_tag(cur_req.addr[ADDR_BITS-1 -: TAG_BITS]),
        .tags(tags),
        .line_states(line_states),
        .hit(hit),
        .hit_way(hit_way),
        .victim_way(victim_way),
        .rr_ptr(rr_ptr)
    );

    tag_next_state #(.TAG_SIZE(TAG_BITS)) i_tag_ns (
        .tag_cur_state(tags),
        .tag_in(cur_req.addr[ADDR_BITS-1 -: TAG_BITS]),
        .is_alloc(tag_we),
        .selected_way(sel_way),
        .tag_next_state(tags_next)
    );

    data_next_state i_data_ns (
        .data_cur_state(data),
        .fill_line(fill_line),
        .fill_sel(fill_sel),
        .store_en(store_en),
        .wdata(cur_req.wdata),
        .offset(cur_req.addr[OFFSET_BITS-1:0]),
        .size(cur_req.size),
        .selected_way(sel_way),
        .data_next_state(data_next),
        .data_evic(evict_line),
        .rewind_data(store_rdata),
        .load_data(load_rdata)
    );

    set_storage #(.NUM_SETS(NUM_SETS)) i_storage (
        .clk(clk),
        .arst_n(arst_n),
        .set_idx(set_idx),
        .tag_we(tag_we),
        .data_we(data_we),
        .state_we(state_we),
        .tags_next(tags_next),
        .data_next(data_next),
        .states_next(next_states),
        .rr_advance(rr_advance),
        .tags(tags),
        .data(data),
        .line_states(line_states),
        .rr_ptr(rr_ptr)
    );

endmodule

`default_nettype wire

//--- verilog/set_storage.sv
`default_nettype none

module set_storage #(
    parameter int NUM_SETS = 4,
    localparam int IDX_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS = cache_pkg::ADDR_BITS - cache_pkg::OFFSET_BITS - IDX_BITS
) (
    input  logic                                             clk,
    input  logic                                             arst_n,
    input  logic [IDX_BITS-1:0]                              set_idx,
    input  logic                                             tag_we,
    input  logic                                             data_we,
    input  logic                                             state_we,
    input  logic [cache_pkg::NUM_WAYS*TAG_BITS-1:0]          tags_next,
    input  logic [cache_pkg::NUM_WAYS*cache_pkg::LINE_BITS-1:0] data_next,
    input  cache_pkg::line_state_e [cache_pkg::NUM_WAYS-1:0] states_next,
    input  logic                                             rr_advance,
    output logic [cache_pkg::NUM_WAYS*TAG_BITS-1:0]          tags,
    output logic [cache_pkg::NUM_WAYS*cache_pkg::LINE_BITS-1:0] data,
    output cache_pkg::line_state_e [cache_pkg::NUM_WAYS-1:0] line_states,
    output logic [$clog2(cache_pkg::NUM_WAYS)-1:0]           rr_ptr
);
    import cache_pkg::*;

    logic [NUM_WAYS*TAG_BITS-1:0] tag_mem [NUM_SETS];
    logic [NUM_WAYS*LINE_BITS-1:0] data_mem [NUM_SETS];
    line_state_e [NUM_WAYS-1:0] state_mem [NUM_SETS];
    logic [$clog2(NUM_WAYS)-1:0] rr_mem [NUM_SETS];

    assign tags = tag_mem[set_idx];
    assign data = data_mem[set_idx];
    assign line_states = state_mem[set_idx];
    assign rr_ptr = rr_mem[set_idx];

    always_ff @(posedge clk) begin
        if (tag_we) begin
            tag_mem[set_idx] <= tags_next;
        end
        if (data_we) begin
            data_mem[set_idx] <= data_next;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int s = 0; s < NUM_SETS; s++) begin
                for (int w = 0; w < NUM_WAYS; w++) begin
                    state_mem[s][w] <= ST_I;
                end
                rr_mem[s] <= '0;
            end
        end else begin
            if (state_we) begin
                state_mem[set_idx] <= states_next;
            end
            if (rr_advance) begin
                rr_mem[set_idx] <= rr_mem[set_idx] + 1'b1;  // Wraps over the ways
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/data_next_state.sv
`default_nettype none

module data_next_state (
    input  logic [cache_pkg::NUM_WAYS*cache_pkg::LINE_BITS-1:0] data_cur_state,
    input  logic [cache_pkg::LINE_BITS-1:0]                     fill_line,
    input  logic                                                fill_sel,
    input  logic                                                store_en,
    input  logic [31:0]                                         wdata,
    input  logic [cache_pkg::OFFSET_BITS-1:0]                   offset,
    input  cache_pkg::access_size_e                             size,
    input  logic [cache_pkg::NUM_WAYS-1:0]                      selected_way,
    output logic [cache_pkg::NUM_WAYS*cache_pkg::LINE_BITS-1:0] data_next_state,
    output logic [cache_pkg::LINE_BITS-1:0]                     data_evic,
    output logic [31:0]                                         rewind_data,
    output logic [31:0]                                         load_data
);
    import cache_pkg::*;

    logic [LINE_BITS-1:0] base_line;
    logic [LINE_BITS-1:0] new_line;
    logic [LINE_BITS+31:0] padded;
    logic [OFFSET_BITS+2:0] bit_pos;

    always_comb begin
        data_evic = data_cur_state[LINE_BITS-1:0];
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (selected_way[w]) begin
                data_evic = data_cur_state[w*LINE_BITS +: LINE_BITS];
            end
        end
    end

    assign base_line = fill_sel ? fill_line : data_evic;
    assign bit_pos = {offset, 3'b000};

    // Bytes past the line end read as zero
    assign padded = {32'b0, base_line};
    assign rewind_data = padded[bit_pos +: 32];

    always_comb begin
        case (size)
            SZ_BYTE: load_data = {24'b0, rewind_data[7:0]};
            SZ_HALF: load_data = {16'b0, rewind_data[15:0]};
            default: load_data = rewind_data;
        endcase
    end

    always_comb begin
        new_line = base_line;
        if (store_en) begin
            case (size)
                SZ_BYTE: new_line[bit_pos +: 8] = wdata[7:0];
                SZ_HALF: new_line[{bit_pos[OFFSET_BITS+2:4], 4'b0} +: 16] = wdata[15:0];
                default: new_line[{bit_pos[OFFSET_BITS+2:5], 5'b0} +: 32] = wdata;
            endcase
        end
    end

    always_comb begin
        data_next_state = data_cur_state;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (selected_way[w]) begin
                data_next_state[w*LINE_BITS +: LINE_BITS] = new_line;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/tag_next_state.sv
`default_nettype none

module tag_next_state #(
    parameter int TAG_SIZE = 26
) (
    input  logic [cache_pkg::NUM_WAYS*TAG_SIZE-1:0] tag_cur_state,
    input  logic [TAG_SIZE-1:0]                     tag_in,
    input  logic                                    is_alloc,
    input  logic [cache_pkg::NUM_WAYS-1:0]          selected_way,
    output logic [cache_pkg::NUM_WAYS*TAG_SIZE-1:0] tag_next_state
);
    import cache_pkg::*;

    always_comb begin
        tag_next_state = tag_cur_state;
        if (is_alloc) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (selected_way[w]) begin
                    tag_next_state[w*TAG_SIZE +: TAG_SIZE] = tag_in;  // One-hot, single slot
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/way_lookup.sv
`default_nettype none

module way_lookup #(
    parameter int NUM_SETS = 4,
    localparam int TAG_BITS = cache_pkg::ADDR_BITS - cache_pkg::OFFSET_BITS - $clog2(NUM_SETS)
) (
    input  logic [TAG_BITS-1:0]                              addr_tag,
    input  logic [cache_pkg::NUM_WAYS*TAG_BITS-1:0]          tags,
    input  cache_pkg::line_state_e [cache_pkg::NUM_WAYS-1:0] line_states,
    output logic                                             hit,
    output logic [cache_pkg::NUM_WAYS-1:0]                   hit_way,
    output logic [cache_pkg::NUM_WAYS-1:0]                   victim_way,
    input  logic [$clog2(cache_pkg::NUM_WAYS)-1:0]           rr_ptr
);
    import cache_pkg::*;

    always_comb begin
        hit_way = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_way[w] = (line_states[w] != ST_I) && (tags[w*TAG_BITS +: TAG_BITS] == addr_tag);
        end
    end

    assign hit = |hit_way;

    // Lowest free way wins over the round-robin pointer
    always_comb begin
        victim_way = '0;
        victim_way[rr_ptr] = 1'b1;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (line_states[w] == ST_I) begin
                victim_way = '0;
                victim_way[w] = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/cache_ctrl.sv
`default_nettype none

module cache_ctrl #(
    parameter int NUM_SETS = 4,
    parameter int REQ_DEPTH = 4,
    parameter int MEM_CREDITS = 2,
    localparam int IDX_BITS = $clog2(NUM_SETS),
    localparam int TAG_BITS = cache_pkg::ADDR_BITS - cache_pkg::OFFSET_BITS - IDX_BITS
) (
    input  logic                                           clk,
    input  logic                                           arst_n,
    input  logic                                           cpu_req_valid,
    input  cache_pkg::cpu_req_t                            cpu_req,
    output logic                                           cpu_req_credit,
    output logic                                           cpu_rsp_valid,
    output cache_pkg::cpu_rsp_t                            cpu_rsp,
    output logic                                           mem_req_valid,
    output cache_pkg::mem_req_t                            mem_req,
    input  logic                                           mem_req_credit,
    input  logic                                           mem_rsp_valid,
    input  cache_pkg::mem_rsp_t                            mem_rsp,
    output logic [IDX_BITS-1:0]                            set_idx,
    output cache_pkg::cpu_req_t                            cur_req,
    output logic                                           store_en,
    output logic [cache_pkg::LINE_BITS-1:0]                fill_line,
    input  logic [cache_pkg::NUM_WAYS*TAG_BITS-1:0]        tags,
    input  cache_pkg::line_state_e [cache_pkg::NUM_WAYS-1:0] line_states,
    input  logic                                           hit,
    input  logic [cache_pkg::NUM_WAYS-1:0]                 hit_way,
    input  logic [cache_pkg::NUM_WAYS-1:0]                 victim_way,
    output logic [cache_pkg::NUM_WAYS-1:0]                 sel_way,
    input  logic [cache_pkg::LINE_BITS-1:0]                evict_line,
    input  logic [31:0]                                    store_rdata,
    input  logic [31:0]                                    load_rdata,
    output logic                                           tag_we,
    output logic                                           data_we,
    output logic                                           state_we,
    output cache_pkg::line_state_e [cache_pkg::NUM_WAYS-1:0] next_states,
    output logic                                           fill_sel,
    output logic                                           rr_advance
);
    import cache_pkg::*;

    localparam int PTR_BITS = (REQ_DEPTH > 1) ? $clog2(REQ_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(REQ_DEPTH + 1);
    localparam int CRD_BITS = $clog2(MEM_CREDITS + 1);

    ctrl_state_e state;
    cpu_req_t queue [REQ_DEPTH];
    logic [PTR_BITS-1:0] wr_ptr;
    logic [PTR_BITS-1:0] rd_ptr;
    logic [CNT_BITS-1:0] q_count;
    logic [CRD_BITS-1:0] mem_crd;
    logic [NUM_WAYS-1:0] way_q;
    logic [31:0] rsp_data;
    logic [TAG_BITS-1:0] evict_tag;
    line_state_e sel_state;
    line_state_e new_state;
    logic deq;
    logic is_store;
    logic mem_send;
    logic fill_done;
    logic hit_store;

    assign deq = (state == IDLE) && (q_count != '0);
    assign cpu_req_credit = deq;
    assign is_store = (cur_req.op == ST);
    assign store_en = is_store;
    assign set_idx = cur_req.addr[OFFSET_BITS +: IDX_BITS];
    assign fill_line = mem_rsp.data;
    assign fill_done = (state == FILL_WAIT) && mem_rsp_valid;
    assign hit_store = (state == LOOKUP) && hit && is_store;
    assign mem_send = ((state == WB_SEND) || (state == FILL_SEND)) && (mem_crd != '0);

    // Way is fixed once the lookup has chosen it
    assign sel_way = (state == LOOKUP) ? (hit ? hit_way : victim_way) : way_q;

    always_comb begin
        evict_tag = '0;
        sel_state = ST_I;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (sel_way[w]) begin
                evict_tag = tags[w*TAG_BITS +: TAG_BITS];
                sel_state = line_states[w];
            end
        end
    end

    assign new_state = (state == FILL_SEND) ? ST_PL : (is_store ? ST_M : ST_S);

    always_comb begin
        next_states = line_states;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (sel_way[w]) begin
                next_states[w] = new_state;
            end
        end
    end

    assign tag_we = (state == FILL_SEND) && mem_send;  // Tag installed with the read
    assign rr_advance = tag_we && (sel_state != ST_I);
    assign state_we = tag_we || fill_done || hit_store;
    assign data_we = fill_done || hit_store;
    assign fill_sel = (state == FILL_WAIT);

    assign mem_req_valid = mem_send;
    assign mem_req.op = (state == WB_SEND) ? MEM_WR : MEM_RD;
    assign mem_req.line_addr = (state == WB_SEND) ? {evict_tag, set_idx}
                                                  : cur_req.addr[ADDR_BITS-1:OFFSET_BITS];
    assign mem_req.data = evict_line;

    assign cpu_rsp_valid = (state == RESPOND);
    assign cpu_rsp.op = cur_req.op;
    assign cpu_rsp.rdata = rsp_data;

    always_ff @(posedge clk) begin
        if (cpu_req_valid) begin
            queue[wr_ptr] <= cpu_req;
        end
        if (deq) begin
            cur_req <= queue[rd_ptr];
        end
        if (state == LOOKUP) begin
            way_q <= sel_way;
        end
        if (((state == LOOKUP) && hit) || fill_done) begin
            rsp_data <= is_store ? store_rdata : load_rdata;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_count <= '0;
            mem_crd <= CRD_BITS'(MEM_CREDITS);
        end else begin
            if (cpu_req_valid) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(REQ_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (deq) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(REQ_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            q_count <= q_count + cpu_req_valid - deq;
            mem_crd <= mem_crd + mem_req_credit - mem_send;
            case (state)
                IDLE: if (deq) state <= LOOKUP;
                LOOKUP: begin
                    if (hit) begin
                        state <= RESPOND;
                    end else if (sel_state == ST_M) begin
                        state <= WB_SEND;  // Dirty victim first
                    end else begin
                        state <= FILL_SEND;
                    end
                end
                WB_SEND: if (mem_send) state <= FILL_SEND;
                FILL_SEND: if (mem_send) state <= FILL_WAIT;
                FILL_WAIT: if (mem_rsp_valid) state <= RESPOND;
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

    localparam int LINE_BYTES = 16;
    localparam int LINE_BITS = 128;
    localparam int NUM_WAYS = 4;
    localparam int ADDR_BITS = 32;
    localparam int OFFSET_BITS = $clog2(LINE_BYTES);
    localparam int LINE_ADDR_BITS = ADDR_BITS - OFFSET_BITS;

    typedef enum logic {
        LD = 1'b0,
        ST = 1'b1
    } cpu_op_e;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } access_size_e;

    typedef enum logic [1:0] {
        ST_I = 2'd0,  // Invalid
        ST_S = 2'd1,  // Shared, clean
        ST_M = 2'd2,  // Modified
        ST_PL = 2'd3  // Fill outstanding
    } line_state_e;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        WB_SEND,
        FILL_SEND,
        FILL_WAIT,
        RESPOND
    } ctrl_state_e;

    typedef enum logic {
        MEM_RD = 1'b0,
        MEM_WR = 1'b1
    } mem_op_e;

    typedef struct packed {
        cpu_op_e op;
        access_size_e size;
        logic [ADDR_BITS-1:0] addr;
        logic [31:0] wdata;
    } cpu_req_t;

    typedef struct packed {
        cpu_op_e op;
        logic [31:0] rdata;
    } cpu_rsp_t;

    typedef struct packed {
        mem_op_e op;
        logic [LINE_ADDR_BITS-1:0] line_addr;
        logic [LINE_BITS-1:0] data;
    } mem_req_t;

    typedef struct packed {
        logic [LINE_BITS-1:0] data;
    } mem_rsp_t;

endpackage

`default_nettype wire
